// File: run.sh
#!/usr/bin/env bash
# builds the reward testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module reward_tb -o reward_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/reward_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qxF "=== PASS ===" <<< "$output"; then
	exit 0
else
	exit 1
fi

// File: sources.f
verilog/reward_pkg.sv
verilog/reward_lfsr.sv
verilog/reward_spot.sv
verilog/reward_timer.sv
verilog/reward_ctrl.sv
verilog/reward_top.sv
testbench/reward_tb.sv

// File: testbench/reward_tb.sv
module reward_tb;

	localparam int NUM_TESTS = 17;
	localparam int REC_WORDS = 8; // id mode status sw hold led flags remaining
	localparam logic [9:0] REWARD_TICKS = 10'd31;

	logic                            clk_4Hz;
	logic                            reset;
	reward_pkg::game_state_t         game_status;
	logic [reward_pkg::COORD_W-1:0]  head_x;
	logic [reward_pkg::COORD_W-1:0]  head_y;
	logic [2:0]                      sw;
	reward_pkg::reward_flags_t       flags;
	logic [15:0]                     led;
	logic [9:0]                      remaining;
	reward_pkg::spot_t               spot;
	logic                            spot_valid;

	logic [15:0] rec [0:NUM_TESTS*REC_WORDS-1];
	logic [reward_pkg::COORD_W-1:0] park_x;
	logic [reward_pkg::COORD_W-1:0] park_y;
	string cur_name;
	int cycles;
	int limit;
	int check_fails;
	int fails_before;
	int tests_run;
	int tests_failed;

	reward_top #(.REWARD_TICKS(REWARD_TICKS), .LFSR_SEED(16'd99)) dut
	(
		.clk_4Hz     (clk_4Hz),
		.reset       (reset),
		.game_status (game_status),
		.head_x      (head_x),
		.head_y      (head_y),
		.sw          (sw),
		.flags       (flags),
		.led         (led),
		.remaining   (remaining),
		.spot        (spot),
		.spot_valid  (spot_valid)
	);

	initial
	begin
		clk_4Hz = 1'b0;
		forever #4 clk_4Hz = ~clk_4Hz;
	end

	// the run may not outlast all hold counts plus some slack
	always @(posedge clk_4Hz)
	begin
		cycles = cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout: the tests did not finish within %0d cycles", limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ----------------------------------------
	// expected values and checks
	// ----------------------------------------

	function automatic logic [15:0] kind_led(input reward_pkg::reward_kind_t kind);
		case (kind)
			reward_pkg::RW_PROTECT: return reward_pkg::LED_PROTECT;
			reward_pkg::RW_SLOW:    return reward_pkg::LED_SLOW;
			reward_pkg::RW_GRADE:   return reward_pkg::LED_GRADE;
			default:                return 16'h0000;
		endcase
	endfunction

	// flag bits run protect, slow, grade from the top
	function automatic logic [15:0] kind_flags(input reward_pkg::reward_kind_t kind);
		case (kind)
			reward_pkg::RW_PROTECT: return 16'h0004;
			reward_pkg::RW_SLOW:    return 16'h0002;
			reward_pkg::RW_GRADE:   return 16'h0001;
			default:                return 16'h0000;
		endcase
	endfunction

	function automatic string mode_name(input logic [1:0] mode);
		case (mode)
			2'd0:    return "switch";
			2'd1:    return "pickup";
			2'd2:    return "pause";
			default: return "idle";
		endcase
	endfunction

	task automatic compare_value(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		assert (act === exp)
		else
		begin
			$display("FAILED %s %s expected %h actual %h", cur_name, what, exp, act);
			check_fails++;
		end
	endtask

	task automatic require(input logic cond, input string msg);
		assert (cond === 1'b1)
		else
		begin
			$display("%s: %s", cur_name, msg);
			check_fails++;
		end
	endtask

	task automatic check_outputs(input logic [15:0] exp_led, input logic [15:0] exp_flags,
		input logic [15:0] exp_rem);
		compare_value("led", exp_led, led);
		compare_value("flags", exp_flags, {13'b0, flags});
		compare_value("remaining", exp_rem, {6'b0, remaining});
	endtask

	// keeps the idle head off the spot so that no pickup happens by chance
	task automatic park_head();
		if (spot_valid === 1'b1 && park_x == spot.x && park_y == spot.y)
			park_x = park_x + 6'd1;
		head_x = park_x;
		head_y = park_y;
	endtask

	task automatic next_tick(input logic on_spot);
		@(posedge clk_4Hz);
		@(negedge clk_4Hz);
		if (on_spot && spot_valid === 1'b1)
		begin
			head_x = spot.x;
			head_y = spot.y;
		end
		else
			park_head();
		if (spot_valid === 1'b1)
			require(spot.kind !== reward_pkg::RW_NONE, "placed spot carries no reward kind");
	endtask

	// ----------------------------------------
	// test kinds
	// ----------------------------------------

	task automatic switch_test(input int base);
		int hold;
		hold = int'(rec[base+4]);
		game_status = reward_pkg::game_state_t'(rec[base+2][1:0]);
		sw = rec[base+3][2:0];
		next_tick(1'b0);
		sw = 3'b000;
		repeat (hold) next_tick(1'b0);
		check_outputs(rec[base+5], rec[base+6], rec[base+7]);
	endtask

	task automatic pickup_test(input int base);
		reward_pkg::reward_kind_t kind;
		int hold;
		hold = int'(rec[base+4]);
		game_status = reward_pkg::ST_RUN;
		sw = 3'b000;
		while (spot_valid !== 1'b1)
			next_tick(1'b0);
		kind = spot.kind;
		head_x = spot.x;
		head_y = spot.y;
		next_tick(1'b0);
		require(spot_valid === 1'b0, "spot still valid one tick after the pickup");
		check_outputs(kind_led(kind), kind_flags(kind), {6'b0, REWARD_TICKS});
		next_tick(1'b0);
		require(spot_valid === 1'b1, "no new spot two ticks after the pickup");
		compare_value("remaining", {6'b0, REWARD_TICKS - 10'd1}, {6'b0, remaining});
		repeat (hold) next_tick(1'b0);
		check_outputs(kind_led(kind), kind_flags(kind), rec[base+7]);
	endtask

	// pause, idle and over all freeze the outputs and the spot
	task automatic frozen_test(input int base);
		reward_pkg::spot_t held_spot;
		logic held_valid;
		int hold;
		hold = int'(rec[base+4]);
		held_spot = spot;
		held_valid = spot_valid;
		game_status = reward_pkg::game_state_t'(rec[base+2][1:0]);
		sw = rec[base+3][2:0];
		if (spot_valid === 1'b1)
		begin
			head_x = spot.x; // bait a pickup that must not happen
			head_y = spot.y;
		end
		repeat (hold)
		begin
			next_tick(1'b1);
			check_outputs(rec[base+5], rec[base+6], rec[base+7]);
			compare_value("spot", {2'b0, held_spot}, {2'b0, spot});
			compare_value("spot_valid", {15'b0, held_valid}, {15'b0, spot_valid});
		end
		sw = 3'b000;
		park_head();
	endtask

	task automatic report_test();
		tests_run++;
		if (check_fails == fails_before)
			$display("%s ok", cur_name);
		else
		begin
			tests_failed++;
			$display("%s %0d checks failed", cur_name, check_fails - fails_before);
		end
	endtask

	initial
	begin
		int base;
		$readmemh("testbench/reward_testdata.txt", rec);
		limit = 64;
		for (int t = 0; t < NUM_TESTS; t++)
			limit = limit + int'(rec[t*REC_WORDS+4]);
		reset = 1'b1;
		game_status = reward_pkg::ST_IDLE;
		sw = 3'b000;
		park_x = '0;
		park_y = '0;
		head_x = '0;
		head_y = '0;
		repeat (3) @(posedge clk_4Hz);
		@(negedge clk_4Hz);
		reset = 1'b0;

		cur_name = "test_00_reset";
		fails_before = check_fails;
		check_outputs(16'h0000, 16'h0000, 16'h0000);
		require(spot_valid === 1'b0, "spot valid right after reset");
		game_status = reward_pkg::ST_RUN;
		next_tick(1'b0);
		require(spot_valid === 1'b1, "no spot placed on the first run tick");
		report_test();

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			base = t * REC_WORDS;
			cur_name = $sformatf("test_%02h_%s", rec[base][7:0], mode_name(rec[base+1][1:0]));
			fails_before = check_fails;
			case (rec[base+1][1:0])
				2'd0:    switch_test(base);
				2'd1:    pickup_test(base);
				default: frozen_test(base);
			endcase
			report_test();
		end

		$display("tests run %0d, passed %0d, failed %0d", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: testbench/reward_testdata.txt
// id mode status sw hold led flags remaining, all hex, one test per line
// mode 0 switch 1 pickup 2 pause 3 idle, flags are protect slow grade
01 0 2 1 00 000F 4 01F
02 0 2 0 1D 000F 4 001
03 0 2 0 00 0000 0 000
04 0 2 2 00 00F0 2 01F
05 0 2 0 09 00F0 2 015
06 0 2 4 00 0F00 1 01F
07 0 2 3 00 0F00 1 01E
08 0 2 7 00 0F00 1 01D
09 2 1 1 0C 0F00 1 01D
0A 0 2 0 04 0F00 1 018
0B 3 0 2 05 0F00 1 018
0C 3 3 1 05 0F00 1 018
0D 0 2 0 00 0F00 1 017
0E 1 2 0 00 0000 0 01E
0F 1 2 0 03 0000 0 01B
10 1 2 0 1D 0000 0 001
11 0 2 0 00 0000 0 000

// File: verilog/reward_ctrl.sv
module reward_ctrl
(
	input  logic                        clk_4Hz,
	input  logic                        reset,
	input  reward_pkg::game_state_t     game_status,
	input  logic [2:0]                  sw,
	input  logic                        valid,
	input  logic                        hit,
	input  reward_pkg::reward_kind_t    spot_kind,
	output logic                        place,
	output logic                        take,
	output logic                        grant,
	output reward_pkg::reward_kind_t    grant_kind,
	output logic                        run
);

	reward_pkg::reward_kind_t sw_kind;

	assign run = (game_status == reward_pkg::ST_RUN);

	// ----------------------------------------
	// switch decode
	// ----------------------------------------

	always_comb
	begin
		case (sw)
			3'b001:  sw_kind = reward_pkg::RW_PROTECT;
			3'b010:  sw_kind = reward_pkg::RW_SLOW;
			3'b100:  sw_kind = reward_pkg::RW_GRADE;
			default: sw_kind = reward_pkg::RW_NONE; // no switch or several at once
		endcase
	end

	// ----------------------------------------
	// grant, pickup and placement
	// ----------------------------------------

	always_comb
	begin
		grant      = 1'b0;
		grant_kind = reward_pkg::RW_NONE;
		take       = 1'b0;
		place      = 1'b0;
		if (run)
		begin
			if (sw_kind != reward_pkg::RW_NONE)
			begin
				grant      = 1'b1;
				grant_kind = sw_kind; // the spot stays where it is
			end
			else if (hit)
			begin
				grant      = 1'b1;
				grant_kind = spot_kind;
				take       = 1'b1;
			end

			// a hit needs a valid spot, so an empty slot never sees a take
			if (!valid)
				place = 1'b1;
		end
	end

	place_take_exclusive: assert property (@(posedge clk_4Hz) disable iff (reset)
		!(place && take))
	else $error("reward_ctrl: place and take in the same tick");

endmodule

// File: verilog/reward_lfsr.sv
module reward_lfsr
#(
	parameter logic [15:0] SEED = 16'hACE1
)
(
	input  logic               clk_4Hz,
	input  logic               reset,
	output reward_pkg::spot_t  cand
);

	// taps for x^16 + x^14 + x^13 + x^11 + 1, maximal length
	localparam logic [15:0] TAPS = 16'hB400;

	localparam int CW = reward_pkg::COORD_W;

	logic [15:0] lfsr;
	reward_pkg::reward_kind_t raw_kind;

	always_ff @(posedge clk_4Hz)
	begin
		if (reset)
			lfsr <= SEED;
		else if (lfsr[0])
			lfsr <= (lfsr >> 1) ^ TAPS;
		else
			lfsr <= lfsr >> 1;
	end

	assign raw_kind = reward_pkg::reward_kind_t'(lfsr[2*CW+1:2*CW]);

	always_comb
	begin
		cand.x    = lfsr[CW-1:0];
		cand.y    = lfsr[2*CW-1:CW];
		cand.kind = raw_kind;
		if (raw_kind == reward_pkg::RW_NONE)
			cand.kind = reward_pkg::RW_PROTECT; // a spot always carries a reward
	end

	// an all-zero register would lock up the sequence for good
	lfsr_nonzero: assert property (@(posedge clk_4Hz) disable iff (reset)
		lfsr != '0)
	else $error("reward_lfsr: register reached zero");

endmodule

// File: verilog/reward_pkg.sv
package reward_pkg;

	// grid coordinates, 64 by 64 cells
	localparam int COORD_W = 6;

	// ----------------------------------------
	// game and reward encodings
	// ----------------------------------------

	typedef enum logic [1:0]
	{
		ST_IDLE  = 2'd0,
		ST_PAUSE = 2'd1,
		ST_RUN   = 2'd2,
		ST_OVER  = 2'd3
	} game_state_t;

	typedef enum logic [1:0]
	{
		RW_NONE    = 2'd0,
		RW_PROTECT = 2'd1,
		RW_SLOW    = 2'd2,
		RW_GRADE   = 2'd3
	} reward_kind_t;

	// one reward spot on the grid, 14 bits
	typedef struct packed
	{
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		reward_kind_t kind;
	} spot_t;

	typedef struct packed
	{
		logic protect;
		logic slow;
		logic grade;
	} reward_flags_t;

	localparam logic [15:0] LED_PROTECT = 16'h000F; // right nibble
	localparam logic [15:0] LED_SLOW    = 16'h00F0;
	localparam logic [15:0] LED_GRADE   = 16'h0F00;

endpackage

// File: verilog/reward_spot.sv
module reward_spot
(
	input  logic                            clk_4Hz,
	input  logic                            reset,
	input  logic                            place,
	input  logic                            take,
	input  reward_pkg::spot_t               cand,
	input  logic [reward_pkg::COORD_W-1:0]  head_x,
	input  logic [reward_pkg::COORD_W-1:0]  head_y,
	output reward_pkg::spot_t               spot,
	output logic                            valid,
	output logic                            hit
);

	// ----------------------------------------
	// placed spot
	// ----------------------------------------

	always_ff @(posedge clk_4Hz)
	begin
		if (reset)
			valid <= 1'b0;
		else if (take)
			valid <= 1'b0; // eaten, a new one comes next tick
		else if (place)
			valid <= 1'b1;
	end

	always_ff @(posedge clk_4Hz)
	begin
		if (place)
			spot <= cand;
	end

	// ----------------------------------------
	// head compare
	// ----------------------------------------

	always_comb
	begin
		hit = 1'b0;
		if (valid && head_x == spot.x && head_y == spot.y)
			hit = 1'b1;
	end

	// the control side only places into an empty slot, otherwise a live spot
	// would move under the snake without being eaten
	place_when_empty: assert property (@(posedge clk_4Hz) disable iff (reset)
		place |-> !valid)
	else $error("reward_spot: place while a spot is still valid");

endmodule

// File: verilog/reward_timer.sv
module reward_timer
#(
	parameter logic [9:0] REWARD_TICKS = 10'd31
)
(
	input  logic                        clk_4Hz,
	input  logic                        reset,
	input  logic                        run,
	input  logic                        grant,
	input  reward_pkg::reward_kind_t    grant_kind,
	output reward_pkg::reward_flags_t   flags,
	output logic [15:0]                 led,
	output logic [9:0]                  remaining
);

	reward_pkg::reward_kind_t active_kind;

	// ----------------------------------------
	// active reward and countdown
	// ----------------------------------------

	always_ff @(posedge clk_4Hz)
	begin
		if (reset)
		begin
			active_kind <= reward_pkg::RW_NONE;
			remaining   <= '0;
		end
		else if (run)
		begin
			if (grant)
			begin
				active_kind <= grant_kind; // replaces whatever was running
				remaining   <= REWARD_TICKS;
			end
			else if (active_kind != reward_pkg::RW_NONE)
			begin
				if (remaining == 10'd1)
				begin
					active_kind <= reward_pkg::RW_NONE;
					remaining   <= '0;
				end
				else
					remaining <= remaining - 10'd1;
			end
		end
	end

	always_comb
	begin
		flags.protect = (active_kind == reward_pkg::RW_PROTECT);
		flags.slow    = (active_kind == reward_pkg::RW_SLOW);
		flags.grade   = (active_kind == reward_pkg::RW_GRADE);
		case (active_kind)
			reward_pkg::RW_PROTECT: led = reward_pkg::LED_PROTECT;
			reward_pkg::RW_SLOW:    led = reward_pkg::LED_SLOW;
			reward_pkg::RW_GRADE:   led = reward_pkg::LED_GRADE;
			default:                led = '0;
		endcase
	end

	// count and kind must run out together
	count_matches_kind: assert property (@(posedge clk_4Hz) disable iff (reset)
		(remaining == '0) == (active_kind == reward_pkg::RW_NONE))
	else $error("reward_timer: remaining out of step with the active kind");

endmodule

// File: verilog/reward_top.sv
module reward_top
#(
	parameter logic [9:0]  REWARD_TICKS = 10'd31,
	parameter logic [15:0] LFSR_SEED    = 16'hACE1
)
(
	input  logic                            clk_4Hz,
	input  logic                            reset,
	input  reward_pkg::game_state_t         game_status,
	input  logic [reward_pkg::COORD_W-1:0]  head_x,
	input  logic [reward_pkg::COORD_W-1:0]  head_y,
	input  logic [2:0]                      sw,
	output reward_pkg::reward_flags_t       flags,
	output logic [15:0]                     led,
	output logic [9:0]                      remaining,
	output reward_pkg::spot_t               spot,
	output logic                            spot_valid
);

	reward_pkg::spot_t          cand;
	reward_pkg::reward_kind_t   grant_kind;
	logic                       place;
	logic                       take;
	logic                       hit;
	logic                       grant;
	logic                       run;

	reward_ctrl u_ctrl
	(
		.clk_4Hz     (clk_4Hz),
		.reset       (reset),
		.game_status (game_status),
		.sw          (sw),
		.valid       (spot_valid),
		.hit         (hit),
		.spot_kind   (spot.kind),
		.place       (place),
		.take        (take),
		.grant       (grant),
		.grant_kind  (grant_kind),
		.run         (run)
	);

	reward_lfsr #(.SEED(LFSR_SEED)) u_lfsr
	(
		.clk_4Hz (clk_4Hz),
		.reset   (reset),
		.cand    (cand)
	);

	reward_spot u_spot
	(
		.clk_4Hz (clk_4Hz),
		.reset   (reset),
		.place   (place),
		.take    (take),
		.cand    (cand),
		.head_x  (head_x),
		.head_y  (head_y),
		.spot    (spot),
		.valid   (spot_valid),
		.hit     (hit)
	);

	reward_timer #(.REWARD_TICKS(REWARD_TICKS)) u_timer
	(
		.clk_4Hz    (clk_4Hz),
		.reset      (reset),
		.run        (run),
		.grant      (grant),
		.grant_kind (grant_kind),
		.flags      (flags),
		.led        (led),
		.remaining  (remaining)
	);

endmodule
